/* source/rvPkg.sv */
package rvPkg;

    typedef logic [31:0] word_t;
    typedef logic [4:0]  regAddr_t;

    typedef enum logic [1:0] {
        fetchSt,
        decodeSt,
        executeSt,
        writebackSt
    } state_t;

    typedef enum logic [3:0] {
        aluAdd, aluSub, aluAnd, aluOr, aluXor,
        aluSlt, aluSltu, aluSll, aluSrl, aluSra,
        aluEq, aluNe, aluLt, aluGe, aluLtu, aluGeu  // Branch conditions
    } aluOp_t;

    typedef enum logic [1:0] {
        immI,
        immS,
        immB,
        immJ
    } immKind_t;

    // Operand B select
    localparam logic [1:0] bRs2  = 2'd0;
    localparam logic [1:0] bImm  = 2'd1;
    localparam logic [1:0] bFour = 2'd2;

    typedef struct packed {
        logic       pcLoad;
        logic       pcFromAlu;  // Target register instead of PC+4
        logic       aSel;       // 1 = rs1, 0 = PC
        logic [1:0] bSel;
        logic       irLoad;
        logic       regWrite;
        logic       memWrite;
        logic       wbFromMem;
        logic       isBranch;
        immKind_t   immKind;
    } ctrlSig_t;

    localparam logic [6:0] opOp    = 7'b0110011;
    localparam logic [6:0] opOpImm = 7'b0010011;
    localparam logic [6:0] opLoad  = 7'b0000011;
    localparam logic [6:0] opStore = 7'b0100011;
    localparam logic [6:0] opBranch = 7'b1100011;
    localparam logic [6:0] opJal   = 7'b1101111;
    localparam logic [6:0] opJalr  = 7'b1100111;

    localparam int imemWords = 256;
    localparam int dmemWords = 256;
    localparam int imemIdxW  = $clog2(imemWords);
    localparam int dmemIdxW  = $clog2(dmemWords);

endpackage

/* source/aluUnit.sv */
module aluUnit (
    input  rvPkg::word_t  a,
    input  rvPkg::word_t  b,
    input  rvPkg::aluOp_t op,
    output rvPkg::word_t  result,
    output logic          taken
);
    import rvPkg::*;

    logic [4:0] shamt;
    logic       ltSigned;
    logic       ltUnsigned;
    logic       equal;

    assign shamt      = b[4:0];
    assign ltSigned   = $signed(a) < $signed(b);
    assign ltUnsigned = a < b;
    assign equal      = a == b;

    always_comb begin
        case (op)
            aluSub:  result = a - b;
            aluAnd:  result = a & b;
            aluOr:   result = a | b;
            aluXor:  result = a ^ b;
            aluSlt:  result = {31'd0, ltSigned};
            aluSltu: result = {31'd0, ltUnsigned};
            aluSll:  result = a << shamt;
            aluSrl:  result = a >> shamt;
            aluSra:  result = word_t'($signed(a) >>> shamt);
            default: result = a + b;  // Add and branch ops
        endcase
    end

    always_comb begin
        case (op)
            aluEq:   taken = equal;
            aluNe:   taken = !equal;
            aluLt:   taken = ltSigned;
            aluGe:   taken = !ltSigned;
            aluLtu:  taken = ltUnsigned;
            aluGeu:  taken = !ltUnsigned;
            default: taken = 1'b0;
        endcase
    end

endmodule

/* source/regFile.sv */
module regFile (
    input  logic            clk,
    input  logic            rstN,
    input  rvPkg::regAddr_t rs1,
    input  rvPkg::regAddr_t rs2,
    input  rvPkg::regAddr_t rd,
    input  logic            we,
    input  rvPkg::word_t    wd,
    output rvPkg::word_t    rd1,
    output rvPkg::word_t    rd2
);
    import rvPkg::*;

    word_t regs [32];

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (we && rd != '0) begin
            regs[rd] <= wd;
        end
    end

    // x0 reads as zero
    assign rd1 = (rs1 == '0) ? '0 : regs[rs1];
    assign rd2 = (rs2 == '0) ? '0 : regs[rs2];

endmodule

/* source/immGen.sv */
module immGen (
    input  rvPkg::word_t    instr,
    input  rvPkg::immKind_t kind,
    output rvPkg::word_t    imm
);
    import rvPkg::*;

    logic sign;

    assign sign = instr[31];

    always_comb begin
        case (kind)
            immS: begin
                imm = {{21{sign}}, instr[30:25], instr[11:7]};
            end
            immB: begin
                imm = {{20{sign}}, instr[7], instr[30:25], instr[11:8], 1'b0};
            end
            immJ: begin
                imm = {{12{sign}}, instr[19:12], instr[20], instr[30:21], 1'b0};
            end
            default: begin
                imm = {{21{sign}}, instr[30:20]};  // I-type, also shifts
            end
        endcase
    end

endmodule

/* source/instrMem.sv */
module instrMem (
    input  logic         clk,
    input  logic         we,
    input  logic         coreBusy,
    input  rvPkg::word_t waddr,
    input  rvPkg::word_t wdata,
    input  rvPkg::word_t raddr,
    output rvPkg::word_t rdata
);
    import rvPkg::*;

    word_t mem [imemWords];

    always_ff @(posedge clk) begin
        if (we) begin
            mem[waddr[imemIdxW+1:2]] <= wdata;
        end
    end

    assign rdata = mem[raddr[imemIdxW+1:2]];

    // Program may only be loaded while the core is halted
    assert property (@(posedge clk) we |-> !coreBusy)
        else $error("Instruction memory written while core running");

endmodule

/* source/dataMem.sv */
module dataMem (
    input  logic         clk,
    input  logic         we,
    input  rvPkg::word_t addr,
    input  rvPkg::word_t wdata,
    output rvPkg::word_t rdata
);
    import rvPkg::*;

    word_t mem [dmemWords];

    always_ff @(posedge clk) begin
        if (we) begin
            mem[addr[dmemIdxW+1:2]] <= wdata;
        end
    end

    assign rdata = mem[addr[dmemIdxW+1:2]];  // Combinational for LW in writeback

    assert property (@(posedge clk) we |-> addr[1:0] == 2'b00)
        else $error("Misaligned SW address %h", addr);

endmodule

/* source/controlUnit.sv */
module controlUnit (
    input  logic            clk,
    input  logic            rstN,
    input  logic            run,
    input  rvPkg::word_t    instr,
    input  logic            aluTaken,
    output rvPkg::ctrlSig_t ctrl,
    output rvPkg::aluOp_t   aluOp,
    output rvPkg::state_t   state
);
    import rvPkg::*;

    logic [6:0] opcode;
    logic [2:0] funct3;
    logic       altBit;
    aluOp_t     arithOp;
    aluOp_t     branchOp;

    assign opcode = instr[6:0];
    assign funct3 = instr[14:12];
    assign altBit = instr[30];

    // Holds in fetch until run, then always completes the instruction
    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            state <= fetchSt;
        end else if (run || state != fetchSt) begin
            state <= state_t'(state + 2'd1);
        end
    end

    always_comb begin
        case (funct3)
            3'b000:  arithOp = (altBit && opcode == opOp) ? aluSub : aluAdd;  // No SUBI
            3'b001:  arithOp = aluSll;
            3'b010:  arithOp = aluSlt;
            3'b011:  arithOp = aluSltu;
            3'b100:  arithOp = aluXor;
            3'b101:  arithOp = altBit ? aluSra : aluSrl;
            3'b110:  arithOp = aluOr;
            default: arithOp = aluAnd;
        endcase
    end

    always_comb begin
        case (funct3)
            3'b000:  branchOp = aluEq;
            3'b001:  branchOp = aluNe;
            3'b100:  branchOp = aluLt;
            3'b101:  branchOp = aluGe;
            3'b110:  branchOp = aluLtu;
            default: branchOp = aluGeu;
        endcase
    end

    always_comb begin
        ctrl  = '0;
        aluOp = aluAdd;

        case (opcode)
            opStore:  ctrl.immKind = immS;
            opBranch: ctrl.immKind = immB;
            opJal:    ctrl.immKind = immJ;
            default:  ctrl.immKind = immI;
        endcase

        case (state)
            fetchSt: begin
                ctrl.irLoad = run;
            end
            decodeSt: begin
                ctrl.aSel = 1'b0;  // PC + imm into target
                ctrl.bSel = bImm;
            end
            executeSt: begin
                ctrl.aSel = 1'b1;
                ctrl.bSel = bImm;  // Loads, stores and JALR use rs1 + imm
                case (opcode)
                    opOp: begin
                        ctrl.bSel = bRs2;
                        aluOp     = arithOp;
                    end
                    opOpImm: begin
                        aluOp = arithOp;
                    end
                    opBranch: begin
                        ctrl.bSel     = bRs2;
                        ctrl.isBranch = 1'b1;
                        aluOp         = branchOp;
                    end
                    default: begin
                        aluOp = aluAdd;
                    end
                endcase
            end
            default: begin
                // Writeback: ALU is free, so it forms PC+4
                ctrl.aSel   = 1'b0;
                ctrl.bSel   = bFour;
                ctrl.pcLoad = 1'b1;
                case (opcode)
                    opOp, opOpImm: begin
                        ctrl.regWrite = 1'b1;
                    end
                    opLoad: begin
                        ctrl.regWrite  = 1'b1;
                        ctrl.wbFromMem = 1'b1;
                    end
                    opStore: begin
                        ctrl.memWrite = 1'b1;
                    end
                    opBranch: begin
                        ctrl.isBranch  = 1'b1;
                        ctrl.pcFromAlu = aluTaken;
                    end
                    opJal, opJalr: begin
                        ctrl.regWrite  = 1'b1;
                        ctrl.pcFromAlu = 1'b1;
                    end
                    default: begin
                        ctrl.pcFromAlu = 1'b0;  // Unknown opcode just steps
                    end
                endcase
            end
        endcase
    end

    // State writes happen in writeback only, never both at once
    assert property (@(posedge clk) disable iff (!rstN)
        (ctrl.regWrite || ctrl.memWrite)
            |-> (state == writebackSt) && !(ctrl.regWrite && ctrl.memWrite))
        else $error("Illegal register/memory write combination");

endmodule

/* source/cpuTop.sv */
module cpuTop (
    input  logic            clk,
    input  logic            rstN,
    input  logic            run,
    input  logic            progWe,
    input  rvPkg::word_t    progAddr,
    input  rvPkg::word_t    progData,
    output rvPkg::word_t    pc,
    output rvPkg::word_t    wbData,
    output rvPkg::regAddr_t wbAddr,
    output logic            wbValid,
    output rvPkg::word_t    instrCount
);
    import rvPkg::*;

    ctrlSig_t ctrl;
    aluOp_t   aluOp;
    state_t   state;

    word_t instr;
    word_t ir;
    word_t rs1Reg;
    word_t rs2Reg;
    word_t immReg;
    word_t targetReg;
    word_t aluOut;
    word_t rd1;
    word_t rd2;
    word_t immNow;
    word_t immSel;
    word_t aluA;
    word_t aluB;
    word_t aluResult;
    word_t memRdata;
    logic  aluTakenNow;
    logic  takenReg;
    logic  isLink;
    logic  isJalr;
    logic  coreBusy;

    assign isJalr   = ir[6:0] == opJalr;
    assign isLink   = (ir[6:0] == opJal) || isJalr;
    assign coreBusy = run || state != fetchSt;

    controlUnit ctrlU (.clk, .rstN, .run, .instr(ir), .aluTaken(takenReg),
                       .ctrl, .aluOp, .state);

    instrMem imem (.clk, .we(progWe), .coreBusy, .waddr(progAddr), .wdata(progData),
                   .raddr(pc), .rdata(instr));

    regFile rf (.clk, .rstN, .rs1(ir[19:15]), .rs2(ir[24:20]), .rd(wbAddr),
                .we(ctrl.regWrite), .wd(wbData), .rd1, .rd2);

    immGen immU (.instr(ir), .kind(ctrl.immKind), .imm(immNow));

    // Immediate register is not loaded until the end of decode
    assign immSel = (state == decodeSt) ? immNow : immReg;
    assign aluA   = ctrl.aSel ? rs1Reg : pc;

    always_comb begin
        case (ctrl.bSel)
            bRs2:    aluB = rs2Reg;
            bImm:    aluB = immSel;
            default: aluB = 32'd4;
        endcase
    end

    aluUnit alu (.a(aluA), .b(aluB), .op(aluOp), .result(aluResult), .taken(aluTakenNow));

    dataMem dmem (.clk, .we(ctrl.memWrite), .addr(aluOut), .wdata(rs2Reg), .rdata(memRdata));

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            pc         <= '0;
            ir         <= '0;
            takenReg   <= 1'b0;
            instrCount <= '0;
        end else begin
            if (ctrl.irLoad) begin
                ir <= instr;
            end
            if (ctrl.pcLoad) begin
                pc <= ctrl.pcFromAlu ? targetReg : aluResult;  // ALU holds PC+4 here
            end
            if (state == executeSt && ctrl.isBranch) begin
                takenReg <= aluTakenNow;
            end
            if (state == writebackSt) begin
                instrCount <= instrCount + 32'd1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (state == decodeSt) begin
            rs1Reg    <= rd1;
            rs2Reg    <= rd2;
            immReg    <= immNow;
            targetReg <= aluResult;  // PC + imm for branches and JAL
        end
        if (state == executeSt) begin
            aluOut <= aluResult;
            if (isJalr) begin
                targetReg <= {aluResult[31:1], 1'b0};
            end
        end
    end

    assign wbAddr  = ir[11:7];
    assign wbData  = ctrl.wbFromMem ? memRdata : (isLink ? aluResult : aluOut);
    assign wbValid = ctrl.regWrite && wbAddr != '0;

endmodule

/* dv/cpuTb.sv */
module cpuTb;
    import rvPkg::*;

    typedef struct packed {
        word_t    pc;
        word_t    instr;
        regAddr_t rd;      // 0 means no writeback pulse
        word_t    value;
        word_t    nextPc;
    } step_t;

    localparam int    retireTimeout = 20;
    localparam int    haltCycles    = 12;
    localparam word_t lastPc        = 32'hc4;
    localparam word_t pausePc       = 32'h5c;  // Halt test after the load

    logic     clk;
    logic     rstN;
    logic     run;
    logic     progWe;
    word_t    progAddr;
    word_t    progData;
    word_t    pc;
    word_t    wbData;
    regAddr_t wbAddr;
    logic     wbValid;
    word_t    instrCount;

    step_t steps[$];
    int    errors;
    int    tests;
    int    failedTests;
    logic  timedOut;
    int    errBefore;
    int    i;
    word_t a;

    cpuTop UUT (.clk, .rstN, .run, .progWe, .progAddr, .progData,
                .pc, .wbData, .wbAddr, .wbValid, .instrCount);

    initial clk = 1'b0;
    always #4 clk = ~clk;

    function automatic word_t rOp(input logic [6:0] f7, input logic [2:0] f3,
                                  input regAddr_t rd, input regAddr_t rs1, input regAddr_t rs2);
        return {f7, rs2, rs1, f3, rd, opOp};
    endfunction

    function automatic word_t iOp(input logic [6:0] op, input logic [2:0] f3,
                                  input regAddr_t rd, input regAddr_t rs1, input logic [11:0] imm);
        return {imm, rs1, f3, rd, op};
    endfunction

    function automatic word_t sOp(input logic [2:0] f3, input regAddr_t rs1,
                                  input regAddr_t rs2, input logic [11:0] imm);
        return {imm[11:5], rs2, rs1, f3, imm[4:0], opStore};
    endfunction

    function automatic word_t bOp(input logic [2:0] f3, input regAddr_t rs1,
                                  input regAddr_t rs2, input logic [12:0] imm);
        return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], opBranch};
    endfunction

    function automatic word_t jOp(input regAddr_t rd, input logic [20:0] imm);
        return {imm[20], imm[10:1], imm[11], imm[19:12], rd, opJal};
    endfunction

    task automatic addStep(input word_t pcVal, input word_t instr, input regAddr_t rd,
                           input word_t value, input word_t nextPc);
        step_t s;
        s.pc     = pcVal;
        s.instr  = instr;
        s.rd     = rd;
        s.value  = value;
        s.nextPc = nextPc;
        steps.push_back(s);
    endtask

    // x1 = -5, x2 = 3 feed most of the ALU and branch rows
    task automatic buildProgram();
        addStep('h00, iOp(opOpImm, 3'b000, 1, 0, 12'hffb), 1, 32'hffff_fffb, 'h04);
        addStep('h04, iOp(opOpImm, 3'b000, 2, 0, 12'h003), 2, 32'h0000_0003, 'h08);
        addStep('h08, rOp(7'h00, 3'b000, 3, 1, 2), 3, 32'hffff_fffe, 'h0c);
        addStep('h0c, rOp(7'h20, 3'b000, 4, 2, 1), 4, 32'h0000_0008, 'h10);
        addStep('h10, rOp(7'h00, 3'b111, 5, 1, 2), 5, 32'h0000_0003, 'h14);
        addStep('h14, rOp(7'h00, 3'b110, 6, 1, 2), 6, 32'hffff_fffb, 'h18);
        addStep('h18, rOp(7'h00, 3'b100, 7, 1, 2), 7, 32'hffff_fff8, 'h1c);
        addStep('h1c, rOp(7'h00, 3'b010, 8, 1, 2), 8, 32'h0000_0001, 'h20);
        addStep('h20, rOp(7'h00, 3'b011, 9, 1, 2), 9, 32'h0000_0000, 'h24);
        addStep('h24, rOp(7'h00, 3'b001, 10, 2, 2), 10, 32'h0000_0018, 'h28);
        addStep('h28, rOp(7'h00, 3'b101, 11, 1, 2), 11, 32'h1fff_ffff, 'h2c);
        addStep('h2c, rOp(7'h20, 3'b101, 12, 1, 2), 12, 32'hffff_ffff, 'h30);
        addStep('h30, iOp(opOpImm, 3'b111, 13, 1, 12'h0f0), 13, 32'h0000_00f0, 'h34);
        addStep('h34, iOp(opOpImm, 3'b110, 14, 2, 12'hff0), 14, 32'hffff_fff3, 'h38);
        addStep('h38, iOp(opOpImm, 3'b100, 15, 1, 12'hfff), 15, 32'h0000_0004, 'h3c);
        addStep('h3c, iOp(opOpImm, 3'b010, 16, 1, 12'hffc), 16, 32'h0000_0001, 'h40);
        addStep('h40, iOp(opOpImm, 3'b011, 17, 2, 12'hfff), 17, 32'h0000_0001, 'h44);
        addStep('h44, iOp(opOpImm, 3'b001, 18, 2, 12'h01f), 18, 32'h8000_0000, 'h48);
        addStep('h48, iOp(opOpImm, 3'b101, 19, 1, 12'h01c), 19, 32'h0000_000f, 'h4c);
        addStep('h4c, iOp(opOpImm, 3'b101, 20, 1, 12'h401), 20, 32'hffff_fffd, 'h50);
        addStep('h50, iOp(opOpImm, 3'b000, 0, 0, 12'h005), 0, 32'h0, 'h54);  // x0 write
        addStep('h54, iOp(opOpImm, 3'b000, 21, 0, 12'h040), 21, 32'h0000_0040, 'h58);
        addStep('h58, sOp(3'b010, 21, 1, 12'h008), 0, 32'h0, 'h5c);
        addStep('h5c, iOp(opLoad, 3'b010, 22, 21, 12'h008), 22, 32'hffff_fffb, 'h60);
        // Taken branches skip one filler word
        addStep('h60, bOp(3'b000, 2, 2, 13'h008), 0, 32'h0, 'h68);
        addStep('h68, bOp(3'b000, 1, 2, 13'h008), 0, 32'h0, 'h6c);
        addStep('h6c, bOp(3'b001, 1, 2, 13'h008), 0, 32'h0, 'h74);
        addStep('h74, bOp(3'b001, 2, 2, 13'h008), 0, 32'h0, 'h78);
        addStep('h78, bOp(3'b100, 1, 2, 13'h008), 0, 32'h0, 'h80);
        addStep('h80, bOp(3'b100, 2, 1, 13'h008), 0, 32'h0, 'h84);
        addStep('h84, bOp(3'b101, 2, 1, 13'h008), 0, 32'h0, 'h8c);
        addStep('h8c, bOp(3'b101, 1, 2, 13'h008), 0, 32'h0, 'h90);
        addStep('h90, bOp(3'b110, 2, 1, 13'h008), 0, 32'h0, 'h98);
        addStep('h98, bOp(3'b110, 1, 2, 13'h008), 0, 32'h0, 'h9c);
        addStep('h9c, bOp(3'b111, 1, 2, 13'h008), 0, 32'h0, 'ha4);
        addStep('ha4, bOp(3'b111, 2, 1, 13'h008), 0, 32'h0, 'ha8);
        addStep('ha8, jOp(23, 21'h00000c), 23, 32'h0000_00ac, 'hb4);
        addStep('hb4, iOp(opOpImm, 3'b000, 24, 0, 12'h0c1), 24, 32'h0000_00c1, 'hb8);
        addStep('hb8, iOp(opJalr, 3'b000, 25, 24, 12'h004), 25, 32'h0000_00bc, 'hc4);
        addStep('hc4, jOp(0, 21'h000000), 0, 32'h0, 'hc4);  // Self loop
    endtask

    task automatic checkWord(input string what, input word_t got, input word_t exp);
        assert (got === exp) else begin
            $display("CHECK FAILED time %0t: %s got %h expected %h", $time, what, got, exp);
            errors++;
        end
    endtask

    task automatic reportTest(input string name, input int errStart);
        tests++;
        if (errors == errStart && !timedOut) begin
            $display("%s: ok", name);
        end else begin
            failedTests++;
            $display("%s: %0d errors", name, errors - errStart);
        end
    endtask

    task automatic writeInstr(input word_t addr, input word_t data);
        @(negedge clk);
        progWe   = 1'b1;
        progAddr = addr;
        progData = data;
    endtask

    task automatic runStep(input step_t s, input int idx);
        word_t    countBefore;
        int       cycles;
        int       wbCount;
        regAddr_t gotRd;
        word_t    gotVal;
        int       errStart;
        errStart    = errors;
        countBefore = instrCount;
        cycles      = 0;
        wbCount     = 0;
        gotRd       = '0;
        gotVal      = '0;
        while (instrCount == countBefore && cycles < retireTimeout) begin
            @(negedge clk);
            cycles++;
            if (wbValid) begin
                wbCount++;
                gotRd  = wbAddr;
                gotVal = wbData;
            end
        end
        if (instrCount == countBefore) begin
            $display("Timed out: the instruction at pc %h never retired", s.pc);
            timedOut = 1'b1;
        end else begin
            checkWord("cycles per instruction", cycles, 4);
            checkWord("instrCount step", instrCount, countBefore + 1);
            checkWord("next pc", pc, s.nextPc);
            checkWord("writeback pulses", wbCount, (s.rd != '0) ? 1 : 0);
            if (s.rd != '0) begin
                checkWord("writeback rd", gotRd, s.rd);
                checkWord("writeback value", gotVal, s.value);
            end
        end
        reportTest($sformatf("step %0d at pc %h", idx, s.pc), errStart);
    endtask

    task automatic holdAndCheck();
        word_t pcHeld;
        word_t countHeld;
        int    errStart;
        int    c;
        errStart  = errors;
        run       = 1'b0;
        pcHeld    = pc;
        countHeld = instrCount;
        for (c = 0; c < haltCycles; c++) begin
            @(negedge clk);
            checkWord("pc while halted", pc, pcHeld);
            checkWord("instrCount while halted", instrCount, countHeld);
            checkWord("wbValid while halted", wbValid, 0);
        end
        run = 1'b1;
        reportTest("run held low", errStart);
    endtask

    initial begin
        rstN        = 1'b0;
        run         = 1'b0;
        progWe      = 1'b0;
        progAddr    = '0;
        progData    = '0;
        errors      = 0;
        tests       = 0;
        failedTests = 0;
        timedOut    = 1'b0;
        buildProgram();
        repeat (5) @(negedge clk);
        rstN = 1'b1;

        errBefore = errors;
        checkWord("pc after reset", pc, 0);
        checkWord("instrCount after reset", instrCount, 0);
        checkWord("wbValid after reset", wbValid, 0);
        reportTest("reset values", errBefore);

        // Filler is addi x31 with its own address, then the program on top
        for (a = 0; a <= lastPc; a += 4) begin
            writeInstr(a, iOp(opOpImm, 3'b000, 31, 0, a[11:0]));
        end
        for (i = 0; i < steps.size(); i++) begin
            writeInstr(steps[i].pc, steps[i].instr);
        end
        @(negedge clk);
        progWe = 1'b0;
        run    = 1'b1;

        for (i = 0; i < steps.size(); i++) begin
            runStep(steps[i], i);
            if (timedOut) begin
                break;
            end
            if (steps[i].pc == pausePc) begin
                holdAndCheck();
            end
        end
        run = 1'b0;

        $display("tests %0d, failed tests %0d, check errors %0d", tests, failedTests, errors);
        if (errors == 0 && !timedOut) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

endmodule

/* list.f */
source/rvPkg.sv
source/aluUnit.sv
source/regFile.sv
source/immGen.sv
source/instrMem.sv
source/dataMem.sv
source/controlUnit.sv
source/cpuTop.sv
dv/cpuTb.sv
